/* logic/bus_pkg.sv */
package bus_pkg;

    // Byte address width of the CPU load/store port
    localparam int ADDR_WIDTH = 32;

    // Word width carried by every stage
    localparam int DATA_WIDTH = 32;

    // One enable bit per byte lane
    localparam int MASK_WIDTH = 4;

    localparam int BYTE_WIDTH = DATA_WIDTH / MASK_WIDTH;

    typedef logic [ADDR_WIDTH-1:0] bus_addr_t;

    typedef logic [DATA_WIDTH-1:0] bus_data_t;

    // Bit n enables byte n, so bit 0 covers data bits 7:0
    typedef logic [MASK_WIDTH-1:0] bus_mask_t;

endpackage

/* logic/mem_map_pkg.sv */
package mem_map_pkg;

    import bus_pkg::*;

    // Each region spans its word count times four bytes from its base

    // Main RAM sits at the bottom of the address space
    localparam bus_addr_t   MAIN_RAM_BASE  = 32'h0000_0000;
    localparam int unsigned MAIN_RAM_WORDS = 1024;

    // Scratchpad sits near the top and well clear of main RAM
    localparam bus_addr_t   SCRATCH_RAM_BASE  = 32'hf000_0000;
    localparam int unsigned SCRATCH_RAM_WORDS = 256;

endpackage

/* logic/mem_bus_if.sv */
`timescale 1ns/10ps

interface mem_bus_if import bus_pkg::*; ();

    // The request stage drives the request side
    bus_addr_t addr;
    bus_data_t wdata;
    bus_mask_t wmask;
    logic      wen;
    logic      ren;

    // A RAM drives the response side for addresses inside its window
    bus_data_t rdata;
    logic      done;

    modport requester (
        output addr,
        output wdata,
        output wmask,
        output wen,
        output ren,
        input  rdata,
        input  done
    );

    modport slave (
        input  addr,
        input  wdata,
        input  wmask,
        input  wen,
        input  ren,
        output rdata,
        output done
    );

    // Observes everything and drives nothing
    modport monitor (
        input addr,
        input wdata,
        input wmask,
        input wen,
        input ren,
        input rdata,
        input done
    );

endinterface

/* logic/request_stage.sv */
`timescale 1ns/10ps

module request_stage
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  bus_addr_t cpu_addr,
    input  bus_data_t cpu_wdata,
    input  bus_mask_t cpu_wmask,
    input  logic      cpu_wen,
    input  logic      cpu_ren,
    mem_bus_if.requester req
);

    // Strobes are one-cycle pulses that start low out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req.wen <= 1'b0;
            req.ren <= 1'b0;
        end else begin
            req.wen <= cpu_wen;
            req.ren <= cpu_ren;
        end
    end

    // Address, data and mask follow the CPU every cycle
    always_ff @(posedge clk) begin
        req.addr  <= cpu_addr;
        req.wdata <= cpu_wdata;
        req.wmask <= cpu_wmask;
    end

    // A single request is either a load or a store
    a_no_read_and_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cpu_wen && cpu_ren)
    ) else $error("request_stage: wen and ren high in the same cycle");

endmodule

/* logic/sim_spram.sv */
`timescale 1ns/10ps

module sim_spram
    import bus_pkg::*;
#(
    parameter bus_addr_t   BASE_ADDR = '0,
    parameter int unsigned WORDS     = 1024
) (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave req,
    mem_bus_if.slave rsp
);

    localparam int OFFSET_BITS = $clog2(MASK_WIDTH);
    localparam int IDX_WIDTH   = (WORDS > 1) ? $clog2(WORDS) : 1;

    // One bit wider than an address so a region ending at the top does not wrap
    localparam logic [ADDR_WIDTH:0] END_ADDR =
        {1'b0, BASE_ADDR} + (ADDR_WIDTH+1)'(WORDS * MASK_WIDTH);

    bus_data_t              memory [WORDS];
    logic                   in_window;
    bus_addr_t              addr_local;
    logic [IDX_WIDTH-1:0]   word_idx;
    logic                   hit_wr;
    logic                   hit_rd;

    assign in_window = ({1'b0, req.addr} >= {1'b0, BASE_ADDR}) &&
                       ({1'b0, req.addr} < END_ADDR);

    // Word index drops the byte offset of the region-relative address
    assign addr_local = req.addr - BASE_ADDR;
    assign word_idx   = addr_local[OFFSET_BITS +: IDX_WIDTH];

    // Strobes outside the window belong to another slave
    assign hit_wr = in_window && req.wen;
    assign hit_rd = in_window && req.ren;

    always_ff @(posedge clk) begin
        if (hit_wr) begin
            for (int b = 0; b < MASK_WIDTH; b++) begin
                if (req.wmask[b]) begin
                    memory[word_idx][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                        req.wdata[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
            // A store echoes the whole written word, not the merged one
            rsp.rdata <= req.wdata;
        end else if (hit_rd) begin
            rsp.rdata <= memory[word_idx];
        end
    end

    // Done is a pulse per request so back-to-back accesses stay distinct
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp.done <= 1'b0;
        end else begin
            rsp.done <= hit_wr || hit_rd;
        end
    end

    a_done_after_strobe : assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.done |-> $past(req.wen || req.ren)
    ) else $error("sim_spram: done without a preceding strobe");

endmodule

/* logic/response_stage.sv */
`timescale 1ns/10ps

module response_stage
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    mem_bus_if.monitor req,
    mem_bus_if.monitor main_rsp,
    mem_bus_if.monitor scratch_rsp,
    output bus_data_t  rdata,
    output logic       done,
    output logic       err
);

    logic due;
    logic any_done;

    // A strobe seen at the RAM inputs means a response arrives next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            due <= 1'b0;
        end else begin
            due <= req.wen || req.ren;
        end
    end

    assign any_done = main_rsp.done || scratch_rsp.done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
            done  <= 1'b0;
            err   <= 1'b0;
        end else begin
            done <= any_done;
            // No slave claimed the address, so it fell between the windows
            err  <= due && !any_done;
            if (main_rsp.done) begin
                rdata <= main_rsp.rdata;
            end else if (scratch_rsp.done) begin
                rdata <= scratch_rsp.rdata;
            end else begin
                rdata <= '0;
            end
        end
    end

    // Windows must not overlap, otherwise the merge above picks one silently
    a_single_slave : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(main_rsp.done && scratch_rsp.done)
    ) else $error("response_stage: both slaves answered the same request");

    a_done_needs_request : assert property (
        @(posedge clk) disable iff (!rst_n)
        any_done |-> due
    ) else $error("response_stage: slave done with no request in flight");

endmodule

/* logic/soc_mem_top.sv */
`timescale 1ns/10ps

module soc_mem_top
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  bus_addr_t cpu_addr,
    input  bus_data_t cpu_wdata,
    input  bus_mask_t cpu_wmask,
    input  logic      cpu_wen,
    input  logic      cpu_ren,
    output bus_data_t rdata,
    output logic      done,
    output logic      err
);

    // One request bus fans out to both RAMs and each answers on its own bus
    mem_bus_if req_bus ();
    mem_bus_if main_rsp ();
    mem_bus_if scratch_rsp ();

    request_stage u_request_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_wmask (cpu_wmask),
        .cpu_wen   (cpu_wen),
        .cpu_ren   (cpu_ren),
        .req       (req_bus)
    );

    sim_spram #(
        .BASE_ADDR (MAIN_RAM_BASE),
        .WORDS     (MAIN_RAM_WORDS)
    ) u_main_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_bus),
        .rsp   (main_rsp)
    );

    sim_spram #(
        .BASE_ADDR (SCRATCH_RAM_BASE),
        .WORDS     (SCRATCH_RAM_WORDS)
    ) u_scratch_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_bus),
        .rsp   (scratch_rsp)
    );

    response_stage u_response_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req_bus),
        .main_rsp    (main_rsp),
        .scratch_rsp (scratch_rsp),
        .rdata       (rdata),
        .done        (done),
        .err         (err)
    );

endmodule

/* tb/soc_mem_vectors.svh */
// Each row holds the operation, byte address, write data, byte mask, expected rdata,
// expected err and a flag that takes the expected rdata from the shadow model
localparam int NUM_VECTORS = 37;

vec_t vectors [NUM_VECTORS] = '{
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
    // Full word write and read back in main RAM
    '{OP_WRITE, 32'h0000_0010, 32'h1234_5678, 4'hf, 32'h1234_5678, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0010, 32'h0000_0000, 4'h0, 32'h1234_5678, 1'b0, 1'b0},
    // Partial masks replace only the enabled bytes
    '{OP_WRITE, 32'h0000_0020, 32'haabb_ccdd, 4'hf, 32'haabb_ccdd, 1'b0, 1'b0},
    '{OP_WRITE, 32'h0000_0020, 32'h1122_3344, 4'h5, 32'h1122_3344, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0020, 32'h0000_0000, 4'h0, 32'haa22_cc44, 1'b0, 1'b0},
    '{OP_WRITE, 32'h0000_0020, 32'h5566_7788, 4'h8, 32'h5566_7788, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0020, 32'h0000_0000, 4'h0, 32'h5522_cc44, 1'b0, 1'b0},
    '{OP_WRITE, 32'h0000_0020, 32'hffff_ffff, 4'h0, 32'hffff_ffff, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0020, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b1},
    // Each region keeps its own data at its edges
    '{OP_WRITE, 32'h0000_0ffc, 32'hdead_beef, 4'hf, 32'hdead_beef, 1'b0, 1'b0},
    '{OP_WRITE, 32'hf000_0000, 32'hcafe_f00d, 4'hf, 32'hcafe_f00d, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0ffc, 32'h0000_0000, 4'h0, 32'hdead_beef, 1'b0, 1'b0},
    '{OP_READ,  32'hf000_0000, 32'h0000_0000, 4'h0, 32'hcafe_f00d, 1'b0, 1'b0},
    '{OP_WRITE, 32'hf000_03fc, 32'h0bad_cafe, 4'hf, 32'h0bad_cafe, 1'b0, 1'b0},
    '{OP_READ,  32'hf000_03fc, 32'h0000_0000, 4'h0, 32'h0bad_cafe, 1'b0, 1'b0},
    // Addresses outside both windows
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_1000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
    '{OP_WRITE, 32'hf000_0400, 32'h1111_1111, 4'hf, 32'h0000_0000, 1'b1, 1'b0},
    '{OP_READ,  32'h8000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0ffc, 32'h0000_0000, 4'h0, 32'hdead_beef, 1'b0, 1'b0},
    // Back-to-back traffic over both regions
    '{OP_WRITE, 32'h0000_0040, 32'h0102_0304, 4'hf, 32'h0102_0304, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0040, 32'h0000_0000, 4'h0, 32'h0102_0304, 1'b0, 1'b0},
    '{OP_READ,  32'hf000_0000, 32'h0000_0000, 4'h0, 32'hcafe_f00d, 1'b0, 1'b0},
    '{OP_WRITE, 32'hf000_0004, 32'h0a0b_0c0d, 4'hf, 32'h0a0b_0c0d, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_1000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 1'b0},
    '{OP_READ,  32'hf000_0004, 32'h0000_0000, 4'h0, 32'h0a0b_0c0d, 1'b0, 1'b0},
    '{OP_WRITE, 32'h0000_0040, 32'hffee_ddcc, 4'h3, 32'hffee_ddcc, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0040, 32'h0000_0000, 4'h0, 32'h0102_ddcc, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0010, 32'h0000_0000, 4'h0, 32'h1234_5678, 1'b0, 1'b0},
    '{OP_WRITE, 32'h0000_0010, 32'h9999_9999, 4'h4, 32'h9999_9999, 1'b0, 1'b0},
    '{OP_READ,  32'h0000_0010, 32'h0000_0000, 4'h0, 32'h1299_5678, 1'b0, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0}
};

/* tb/soc_mem_tb.sv */
`timescale 1ns/10ps

module soc_mem_tb
    import bus_pkg::*;
    import mem_map_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_COUNT   = 200;

    typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE} op_e;

    typedef struct packed {
        op_e       op;
        bus_addr_t addr;
        bus_data_t wdata;
        bus_mask_t mask;
        bus_data_t exp_rdata;
        logic      exp_err;
        logic      from_model;
    } vec_t;

    `include "soc_mem_vectors.svh"

    localparam int WATCHDOG_CYCLES = (NUM_VECTORS + RAND_COUNT) * 4 + RESET_CYCLES;

    logic      clk = 1'b0;
    logic      rst_n;
    bus_addr_t cpu_addr;
    bus_data_t cpu_wdata;
    bus_mask_t cpu_wmask;
    logic      cpu_wen;
    logic      cpu_ren;
    bus_data_t rdata;
    logic      done;
    logic      err;

    // Expected responses of the last three requests with slot 2 due now
    logic      pend_valid [3];
    logic      pend_err [3];
    bus_data_t pend_rdata [3];

    bus_data_t main_shadow [MAIN_RAM_WORDS];
    logic      main_written [MAIN_RAM_WORDS];
    bus_data_t scratch_shadow [SCRATCH_RAM_WORDS];
    logic      scratch_written [SCRATCH_RAM_WORDS];

    integer seed;

    soc_mem_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_wmask (cpu_wmask),
        .cpu_wen   (cpu_wen),
        .cpu_ren   (cpu_ren),
        .rdata     (rdata),
        .done      (done),
        .err       (err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s at %0t ns: got 0x%08h, expected 0x%08h",
                     name, $time, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Returns 0 for main RAM, 1 for scratch RAM, -1 outside both windows
    function automatic int region_of(input bus_addr_t addr);
        bus_addr_t main_off;
        bus_addr_t scratch_off;
        main_off    = addr - MAIN_RAM_BASE;
        scratch_off = addr - SCRATCH_RAM_BASE;
        if (main_off < MAIN_RAM_WORDS * 4) begin
            return 0;
        end else if (scratch_off < SCRATCH_RAM_WORDS * 4) begin
            return 1;
        end
        return -1;
    endfunction

    function automatic int word_of(input bus_addr_t addr);
        if (region_of(addr) == 1) begin
            return int'((addr - SCRATCH_RAM_BASE) >> 2);
        end
        return int'((addr - MAIN_RAM_BASE) >> 2);
    endfunction

    function automatic bus_data_t merge_bytes(input bus_data_t old_word,
                                              input bus_data_t new_word,
                                              input bus_mask_t mask);
        bus_data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic bus_data_t shadow_read(input bus_addr_t addr);
        if (region_of(addr) == 1) begin
            return scratch_shadow[word_of(addr)];
        end
        return main_shadow[word_of(addr)];
    endfunction

    function automatic logic was_written(input bus_addr_t addr);
        if (region_of(addr) == 1) begin
            return scratch_written[word_of(addr)];
        end
        return main_written[word_of(addr)];
    endfunction

    task automatic shadow_write(input bus_addr_t addr, input bus_data_t wdata,
                                input bus_mask_t mask);
        int idx;
        idx = word_of(addr);
        if (region_of(addr) == 1) begin
            scratch_shadow[idx]  = merge_bytes(scratch_shadow[idx], wdata, mask);
            scratch_written[idx] = 1'b1;
        end else begin
            main_shadow[idx]  = merge_bytes(main_shadow[idx], wdata, mask);
            main_written[idx] = 1'b1;
        end
    endtask

    // Checks the response due in this cycle and then drives the next request
    task automatic issue_request(input op_e op, input bus_addr_t addr,
                                 input bus_data_t wdata, input bus_mask_t mask,
                                 input bus_data_t exp_rdata, input logic exp_err);
        @(posedge clk);
        #DRIVE_DELAY;
        if (pend_valid[2]) begin
            compare("done", 32'(done), 32'(!pend_err[2]));
            compare("err", 32'(err), 32'(pend_err[2]));
            compare("rdata", rdata, pend_rdata[2]);
        end else begin
            compare("done", 32'(done), 32'h0);
            compare("err", 32'(err), 32'h0);
        end
        for (int s = 2; s > 0; s--) begin
            pend_valid[s] = pend_valid[s-1];
            pend_err[s]   = pend_err[s-1];
            pend_rdata[s] = pend_rdata[s-1];
        end
        pend_valid[0] = (op != OP_IDLE);
        pend_err[0]   = exp_err;
        pend_rdata[0] = exp_rdata;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_wmask = mask;
        cpu_wen   = (op == OP_WRITE);
        cpu_ren   = (op == OP_READ);
    endtask

    initial begin
        vec_t        vec;
        bus_data_t   expected;
        logic [31:0] rnd;
        bus_addr_t   region_base;
        int unsigned region_words;
        int unsigned word_idx;
        bus_addr_t   addr;
        bus_data_t   wdata;
        bus_mask_t   mask;

        seed      = 32'hfd19_f10d;
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wmask = '0;
        cpu_wen   = 1'b0;
        cpu_ren   = 1'b0;
        for (int s = 0; s < 3; s++) begin
            pend_valid[s] = 1'b0;
            pend_err[s]   = 1'b0;
            pend_rdata[s] = '0;
        end
        for (int i = 0; i < MAIN_RAM_WORDS; i++) begin
            main_written[i] = 1'b0;
        end
        for (int i = 0; i < SCRATCH_RAM_WORDS; i++) begin
            scratch_written[i] = 1'b0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        compare("rdata", rdata, 32'h0);
        compare("done", 32'(done), 32'h0);
        compare("err", 32'(err), 32'h0);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            vec      = vectors[i];
            expected = vec.from_model ? shadow_read(vec.addr) : vec.exp_rdata;
            if (vec.op == OP_WRITE && !vec.exp_err) begin
                shadow_write(vec.addr, vec.wdata, vec.mask);
            end
            issue_request(vec.op, vec.addr, vec.wdata, vec.mask, expected, vec.exp_err);
        end

        // Random traffic on a few words at each end of both regions
        for (int n = 0; n < RAND_COUNT; n++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                region_base  = SCRATCH_RAM_BASE;
                region_words = SCRATCH_RAM_WORDS;
            end else begin
                region_base  = MAIN_RAM_BASE;
                region_words = MAIN_RAM_WORDS;
            end
            word_idx = int'(rnd[5:2]);
            if (rnd[6]) begin
                word_idx = region_words - 1 - word_idx;
            end
            addr  = region_base + bus_addr_t'(word_idx << 2);
            wdata = $random(seed);
            mask  = rnd[11:8];
            if (rnd[1] || !was_written(addr)) begin
                // A fresh word gets a full write so its reads are fully known
                if (!was_written(addr)) begin
                    mask = 4'hf;
                end
                shadow_write(addr, wdata, mask);
                issue_request(OP_WRITE, addr, wdata, mask, wdata, 1'b0);
            end else begin
                issue_request(OP_READ, addr, '0, '0, shadow_read(addr), 1'b0);
            end
        end

        repeat (3) issue_request(OP_IDLE, '0, '0, '0, '0, 1'b0);

        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the test sequence ended",
                 WATCHDOG_CYCLES);
        $display("Finished with errors");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* soc_mem.f */
+incdir+tb
logic/bus_pkg.sv
logic/mem_map_pkg.sv
logic/mem_bus_if.sv
logic/request_stage.sv
logic/sim_spram.sv
logic/response_stage.sv
logic/soc_mem_top.sv
tb/soc_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module soc_mem_tb \
    -f soc_mem.f \
    && ./obj_dir/Vsoc_mem_tb | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0
